//--- common/arp_pkg.sv
package arp_pkg;

    localparam logic [15:0] eth_type_arp   = 16'h0806;
    localparam logic [15:0] arp_hard_type  = 16'h0001;     // ethernet
    localparam logic [15:0] arp_proto_type = 16'h0800;     // ipv4
    localparam logic [15:0] arp_op_req     = 16'h0001;
    localparam logic [15:0] arp_op_rep     = 16'h0002;
    localparam logic [7:0]  arp_hlen       = 8'h06;
    localparam logic [7:0]  arp_plen       = 8'h04;

    localparam logic [7:0]  preamble_byte  = 8'h55;
    localparam logic [7:0]  sfd_byte       = 8'hd5;
    localparam logic [47:0] bcast_mac      = 48'hffff_ffff_ffff;

    localparam int preamble_len      = 7;                   // 55 bytes before the sfd
    localparam int eth_hdr_len       = 14;
    localparam int arp_hdr_len       = 8;
    localparam int arp_addr_len      = 20;
    localparam int reply_frame_bytes = 60;                  // padded, fcs not included
    localparam int fcs_bytes         = 4;
    localparam int ifg_cycles        = 12;

    // reflected form of 04c11db7
    localparam logic [31:0] crc32_poly_rev = 32'hedb8_8320;

    localparam int req_fifo_depth = 4;
    localparam int req_fifo_aw    = $clog2(req_fifo_depth);
    localparam int req_fifo_cw    = $clog2(req_fifo_depth + 1);
    localparam logic [req_fifo_aw-1:0] req_fifo_last = req_fifo_aw'(req_fifo_depth - 1);
    localparam logic [req_fifo_cw-1:0] req_fifo_full = req_fifo_cw'(req_fifo_depth);

    // one-hot parser states
    localparam logic [4:0] rx_st_idle     = 5'b0_0001;
    localparam logic [4:0] rx_st_preamble = 5'b0_0010;
    localparam logic [4:0] rx_st_eth_head = 5'b0_0100;
    localparam logic [4:0] rx_st_arp_head = 5'b0_1000;
    localparam logic [4:0] rx_st_arp_data = 5'b1_0000;

    typedef struct packed {
        logic [47:0] sender_mac;
        logic [31:0] sender_ip;
    } arp_req_t;

endpackage

//--- arp_rx/arp_rx.sv
`timescale 1ns/1ps

module arp_rx (
    input  logic              rstn,
    input  logic              gmii_rx_clk,
    input  logic              gmii_rx_dv,
    input  logic [7:0]        gmii_rxd,
    input  logic [31:0]       board_ip,
    output arp_pkg::arp_req_t req,
    output logic              req_valid
);

    logic [4:0]  state;
    logic [4:0]  next_state;
    logic [4:0]  cnt;
    logic        skip_en;       // section passed
    logic        error_en;      // section failed
    logic [47:0] eth_dst_mac;
    logic [7:0]  eth_type_hi;
    logic [15:0] hard_type;
    logic [15:0] proto_type;
    logic [7:0]  op_hi;
    logic [47:0] src_mac;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic        addr_done;
    logic        accept;

    // decision is taken on the byte after the target ip
    assign addr_done = gmii_rx_dv && (next_state == arp_pkg::rx_st_arp_data)
                       && (cnt == 5'(arp_pkg::arp_addr_len));
    assign accept    = addr_done && (dst_ip == board_ip);

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn)
            state <= arp_pkg::rx_st_idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            arp_pkg::rx_st_idle: begin
                if (skip_en)
                    next_state = arp_pkg::rx_st_preamble;
            end
            arp_pkg::rx_st_preamble: begin
                if (skip_en)
                    next_state = arp_pkg::rx_st_eth_head;
                else if (error_en)
                    next_state = arp_pkg::rx_st_idle;
            end
            arp_pkg::rx_st_eth_head: begin
                if (skip_en)
                    next_state = arp_pkg::rx_st_arp_head;
                else if (error_en)
                    next_state = arp_pkg::rx_st_idle;
            end
            arp_pkg::rx_st_arp_head: begin
                if (skip_en)
                    next_state = arp_pkg::rx_st_arp_data;
                else if (error_en)
                    next_state = arp_pkg::rx_st_idle;
            end
            arp_pkg::rx_st_arp_data: begin
                if (skip_en || error_en)
                    next_state = arp_pkg::rx_st_idle;
            end
            default: next_state = arp_pkg::rx_st_idle;
        endcase
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            skip_en   <= 1'b0;
            error_en  <= 1'b0;
            cnt       <= 5'd0;
            req_valid <= 1'b0;
        end else begin
            skip_en   <= 1'b0;
            error_en  <= 1'b0;
            req_valid <= 1'b0;
            case (next_state)
                arp_pkg::rx_st_idle: begin
                    cnt     <= 5'd0;
                    skip_en <= gmii_rx_dv && (gmii_rxd == arp_pkg::preamble_byte);
                end
                arp_pkg::rx_st_preamble: begin
                    if (gmii_rx_dv) begin
                        cnt <= cnt + 5'd1;
                        if ((cnt < 5'(arp_pkg::preamble_len - 1))
                                && (gmii_rxd != arp_pkg::preamble_byte)) begin
                            error_en <= 1'b1;
                        end else if (cnt == 5'(arp_pkg::preamble_len - 1)) begin
                            cnt <= 5'd0;
                            if (gmii_rxd == arp_pkg::sfd_byte)
                                skip_en <= 1'b1;
                            else
                                error_en <= 1'b1;
                        end
                    end
                end
                arp_pkg::rx_st_eth_head: begin
                    if (gmii_rx_dv) begin
                        cnt <= cnt + 5'd1;
                        if (cnt == 5'(arp_pkg::eth_hdr_len - 1)) begin
                            cnt <= 5'd0;
                            if ((eth_dst_mac == arp_pkg::bcast_mac)
                                    && (eth_type_hi == arp_pkg::eth_type_arp[15:8])
                                    && (gmii_rxd == arp_pkg::eth_type_arp[7:0]))
                                skip_en <= 1'b1;
                            else
                                error_en <= 1'b1;
                        end
                    end
                end
                arp_pkg::rx_st_arp_head: begin
                    if (gmii_rx_dv) begin
                        cnt <= cnt + 5'd1;
                        if (cnt == 5'(arp_pkg::arp_hdr_len - 1)) begin
                            cnt <= 5'd0;
                            if ((hard_type == arp_pkg::arp_hard_type)
                                    && (proto_type == arp_pkg::arp_proto_type)
                                    && ({op_hi, gmii_rxd} == arp_pkg::arp_op_req))
                                skip_en <= 1'b1;
                            else
                                error_en <= 1'b1;
                        end
                    end
                end
                arp_pkg::rx_st_arp_data: begin
                    if (gmii_rx_dv)
                        cnt <= cnt + 5'd1;
                    if (addr_done) begin
                        cnt <= 5'd0;
                        if (accept) begin
                            skip_en   <= 1'b1;
                            req_valid <= 1'b1;
                        end else begin
                            error_en  <= 1'b1;
                        end
                    end
                end
                default: cnt <= 5'd0;
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (gmii_rx_dv) begin
            case (next_state)
                arp_pkg::rx_st_eth_head: begin
                    if (cnt < 5'd6)
                        eth_dst_mac <= {eth_dst_mac[39:0], gmii_rxd};
                    else if (cnt == 5'(arp_pkg::eth_hdr_len - 2))
                        eth_type_hi <= gmii_rxd;
                end
                arp_pkg::rx_st_arp_head: begin
                    if (cnt < 5'd2)
                        hard_type <= {hard_type[7:0], gmii_rxd};
                    else if (cnt < 5'd4)
                        proto_type <= {proto_type[7:0], gmii_rxd};
                    else if (cnt == 5'd6)
                        op_hi <= gmii_rxd;        // lengths at 4 and 5 are ignored
                end
                arp_pkg::rx_st_arp_data: begin
                    if (cnt < 5'd6)
                        src_mac <= {src_mac[39:0], gmii_rxd};
                    else if (cnt < 5'd10)
                        src_ip <= {src_ip[23:0], gmii_rxd};
                    else if ((cnt >= 5'd16) && (cnt < 5'd20))
                        dst_ip <= {dst_ip[23:0], gmii_rxd};   // target mac is skipped
                end
                default: ;
            endcase
        end
        if (accept)
            req <= '{sender_mac: src_mac, sender_ip: src_ip};
    end

endmodule

//--- verilog/arp_req_fifo.sv
`timescale 1ns/1ps

module arp_req_fifo (
    input  logic              rstn,
    input  logic              gmii_rx_clk,
    input  logic              wr,
    input  arp_pkg::arp_req_t wr_data,
    input  logic              pop,
    output arp_pkg::arp_req_t head,
    output logic              not_empty
);

    arp_pkg::arp_req_t mem [arp_pkg::req_fifo_depth];

    logic [arp_pkg::req_fifo_aw-1:0] wr_ptr;
    logic [arp_pkg::req_fifo_aw-1:0] rd_ptr;
    logic [arp_pkg::req_fifo_cw-1:0] count;
    logic                            do_wr;
    logic                            do_rd;

    assign not_empty = (count != '0);
    assign do_wr     = wr && (count != arp_pkg::req_fifo_full);   // drop when full
    assign do_rd     = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                if (wr_ptr == arp_pkg::req_fifo_last)
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                if (rd_ptr == arp_pkg::req_fifo_last)
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

//--- arp_tx/arp_tx.sv
`timescale 1ns/1ps

module arp_tx (
    input  logic              rstn,
    input  logic              gmii_rx_clk,
    input  logic [31:0]       board_ip,
    input  logic [47:0]       board_mac,
    input  arp_pkg::arp_req_t head,
    input  logic              not_empty,
    output logic              pop,
    output logic              gmii_tx_en,
    output logic [7:0]        gmii_txd
);

    arp_pkg::arp_req_t req_q;
    logic [6:0]  idx;           // byte loaded at the next edge
    logic [6:0]  frame_pos;
    logic [1:0]  fcs_pos;
    logic        in_frame;
    logic [3:0]  gap_cnt;
    logic [31:0] crc;
    logic [31:0] fcs;
    logic [7:0]  frame_byte;
    logic [7:0]  tx_byte;

    function automatic logic [7:0] mac_byte(input logic [47:0] mac, input logic [6:0] pos);
        return mac[47 - 8 * pos -: 8];
    endfunction

    function automatic logic [7:0] ip_byte(input logic [31:0] ip, input logic [6:0] pos);
        return ip[31 - 8 * pos -: 8];
    endfunction

    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ arp_pkg::crc32_poly_rev;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    assign frame_pos = idx - 7'(arp_pkg::preamble_len + 1);
    assign in_frame  = (idx > 7'(arp_pkg::preamble_len))
                       && (frame_pos < 7'(arp_pkg::reply_frame_bytes));
    assign fcs_pos   = 2'(frame_pos - 7'(arp_pkg::reply_frame_bytes));
    assign fcs       = ~crc;
    assign pop       = !gmii_tx_en && (gap_cnt == 4'd0) && not_empty;

    always_comb begin
        case (frame_pos) inside
            [7'd0:7'd5]:   frame_byte = mac_byte(req_q.sender_mac, frame_pos);
            [7'd6:7'd11]:  frame_byte = mac_byte(board_mac, frame_pos - 7'd6);
            7'd12:         frame_byte = arp_pkg::eth_type_arp[15:8];
            7'd13:         frame_byte = arp_pkg::eth_type_arp[7:0];
            7'd14:         frame_byte = arp_pkg::arp_hard_type[15:8];
            7'd15:         frame_byte = arp_pkg::arp_hard_type[7:0];
            7'd16:         frame_byte = arp_pkg::arp_proto_type[15:8];
            7'd17:         frame_byte = arp_pkg::arp_proto_type[7:0];
            7'd18:         frame_byte = arp_pkg::arp_hlen;
            7'd19:         frame_byte = arp_pkg::arp_plen;
            7'd20:         frame_byte = arp_pkg::arp_op_rep[15:8];
            7'd21:         frame_byte = arp_pkg::arp_op_rep[7:0];
            [7'd22:7'd27]: frame_byte = mac_byte(board_mac, frame_pos - 7'd22);
            [7'd28:7'd31]: frame_byte = ip_byte(board_ip, frame_pos - 7'd28);
            [7'd32:7'd37]: frame_byte = mac_byte(req_q.sender_mac, frame_pos - 7'd32);
            [7'd38:7'd41]: frame_byte = ip_byte(req_q.sender_ip, frame_pos - 7'd38);
            default:       frame_byte = 8'h00;      // padding
        endcase
    end

    always_comb begin
        if (idx < 7'(arp_pkg::preamble_len))
            tx_byte = arp_pkg::preamble_byte;
        else if (idx == 7'(arp_pkg::preamble_len))
            tx_byte = arp_pkg::sfd_byte;
        else if (in_frame)
            tx_byte = frame_byte;
        else
            tx_byte = fcs[8 * fcs_pos +: 8];        // low byte first
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'h00;
            idx        <= 7'd0;
            gap_cnt    <= 4'd0;
        end else if (pop) begin
            gmii_tx_en <= 1'b1;
            gmii_txd   <= arp_pkg::preamble_byte;
            idx        <= 7'd1;
        end else if (gmii_tx_en) begin
            if (idx == 7'(arp_pkg::preamble_len + 1 + arp_pkg::reply_frame_bytes
                          + arp_pkg::fcs_bytes)) begin
                gmii_tx_en <= 1'b0;
                gmii_txd   <= 8'h00;
                gap_cnt    <= 4'(arp_pkg::ifg_cycles);
            end else begin
                gmii_txd <= tx_byte;
                idx      <= idx + 7'd1;
            end
        end else if (gap_cnt != 4'd0) begin
            gap_cnt <= gap_cnt - 4'd1;
        end
    end

    // crc runs over the bytes as they are loaded
    always_ff @(posedge gmii_rx_clk) begin
        if (pop) begin
            req_q <= head;
            crc   <= '1;
        end else if (gmii_tx_en && in_frame) begin
            crc <= crc32_byte(crc, tx_byte);
        end
    end

endmodule

//--- verilog/arp_top.sv
`timescale 1ns/1ps

module arp_top (
    input  logic        rstn,
    input  logic        gmii_rx_clk,
    input  logic        gmii_rx_dv,
    input  logic [7:0]  gmii_rxd,
    input  logic [31:0] board_ip,
    input  logic [47:0] board_mac,
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd
);

    arp_pkg::arp_req_t req;
    arp_pkg::arp_req_t head;
    logic              req_valid;
    logic              not_empty;
    logic              pop;

    arp_rx u_arp_rx (
        .rstn        (rstn),
        .gmii_rx_clk (gmii_rx_clk),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rxd    (gmii_rxd),
        .board_ip    (board_ip),
        .req         (req),
        .req_valid   (req_valid)
    );

    arp_req_fifo u_req_fifo (
        .rstn        (rstn),
        .gmii_rx_clk (gmii_rx_clk),
        .wr          (req_valid),
        .wr_data     (req),
        .pop         (pop),
        .head        (head),
        .not_empty   (not_empty)
    );

    arp_tx u_arp_tx (
        .rstn        (rstn),
        .gmii_rx_clk (gmii_rx_clk),
        .board_ip    (board_ip),
        .board_mac   (board_mac),
        .head        (head),
        .not_empty   (not_empty),
        .pop         (pop),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd)
    );

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);      // three rising edges held in reset
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

//--- test/arp_tb.sv
`timescale 1ns/1ps

module arp_tb;

    localparam int num_cases   = 11;
    localparam int wire_len    = 72;        // preamble, sfd, 60 bytes, fcs
    localparam int timeout_cyc = num_cases * 200 + 500;
    localparam int last_addr   = 50;        // wire byte that completes a request

    localparam logic [2:0] k_none     = 3'd0;
    localparam logic [2:0] k_bad_pre  = 3'd1;
    localparam logic [2:0] k_bad_sfd  = 3'd2;
    localparam logic [2:0] k_unicast  = 3'd3;
    localparam logic [2:0] k_bad_type = 3'd4;
    localparam logic [2:0] k_bad_op   = 3'd5;
    localparam logic [2:0] k_bad_ip   = 3'd6;

    typedef struct packed {
        logic [2:0]  kind;
        logic [47:0] mac;
        logic [31:0] ip;
        logic        reply;
    } case_t;

    logic        gmii_rx_clk;
    logic        rstn;
    logic        gmii_rx_dv;
    logic [7:0]  gmii_rxd;
    logic [31:0] board_ip;
    logic [47:0] board_mac;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;

    case_t       cases [num_cases];
    logic [79:0] expect_q [$];              // sender mac and ip per pending reply
    logic [7:0]  reply_bytes [$];
    logic [7:0]  exp_reply [wire_len];
    int          seed;
    int          mismatches = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          idle_run = 0;
    int          replies_seen = 0;
    int          requests_done = 0;
    logic        in_reply = 1'b0;

    tb_clk_gen u_clk_gen (
        .clk  (gmii_rx_clk),
        .rstn (rstn)
    );

    arp_top UUT (
        .rstn        (rstn),
        .gmii_rx_clk (gmii_rx_clk),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rxd    (gmii_rxd),
        .board_ip    (board_ip),
        .board_mac   (board_mac),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd)
    );

    function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int b = 0; b < 8; b++)
            c = (c >> 1) ^ (32'hedb8_8320 & {32{c[0]}});
        return c;
    endfunction

    task automatic build_reply(input logic [47:0] mac, input logic [31:0] ip);
        logic [8*42-1:0] body;
        logic [31:0]     crc;
        body = {mac, board_mac, 16'h0806, 16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0002,
                board_mac, board_ip, mac, ip};
        for (int i = 0; i < wire_len; i++)
            exp_reply[i] = (i < 7) ? 8'h55 : 8'h00;
        exp_reply[7] = 8'hd5;
        for (int i = 0; i < 42; i++)
            exp_reply[8 + i] = body[8*42-1 - 8 * i -: 8];
        crc = 32'hffff_ffff;
        for (int i = 8; i < 68; i++)
            crc = crc32_update(crc, exp_reply[i]);
        crc = ~crc;
        for (int i = 0; i < 4; i++)
            exp_reply[68 + i] = crc[8 * i +: 8];       // fcs goes out low byte first
    endtask

    task automatic send_frame(input case_t tc);
        logic [8*42-1:0] body;
        logic [7:0]      wire_bytes [wire_len];
        logic [47:0]     dst;
        logic [15:0]     etype;
        logic [15:0]     op;
        logic [31:0]     tip;
        dst   = (tc.kind == k_unicast) ? board_mac : 48'hffff_ffff_ffff;
        etype = (tc.kind == k_bad_type) ? 16'h0800 : 16'h0806;
        op    = (tc.kind == k_bad_op) ? 16'h0002 : 16'h0001;
        tip   = (tc.kind == k_bad_ip) ? (board_ip ^ 32'h0000_0100) : board_ip;
        body  = {dst, tc.mac, etype, 16'h0001, 16'h0800, 8'h06, 8'h04, op,
                 tc.mac, tc.ip, 48'h0, tip};
        for (int i = 0; i < wire_len; i++)
            wire_bytes[i] = (i < 7) ? 8'h55 : 8'h00;
        wire_bytes[7] = 8'hd5;
        for (int i = 0; i < 42; i++)
            wire_bytes[8 + i] = body[8*42-1 - 8 * i -: 8];
        for (int i = 0; i < 4; i++)
            wire_bytes[68 + i] = 8'h12 + 8'(i * 8'h31);  // dummy fcs, never 55
        if (tc.kind == k_bad_pre)
            wire_bytes[3] = 8'h5d;
        if (tc.kind == k_bad_sfd)
            wire_bytes[7] = 8'hd4;
        if (tc.reply)
            expect_q.push_back({tc.mac, tc.ip});
        for (int i = 0; i < wire_len; i++) begin
            @(negedge gmii_rx_clk);
            gmii_rx_dv = 1'b1;
            gmii_rxd   = wire_bytes[i];
            if (tc.reply && (i == last_addr))
                requests_done++;
        end
        @(negedge gmii_rx_clk);
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        repeat (11) @(negedge gmii_rx_clk);           // 12 idle cycles in all
    endtask

    task automatic check_reply();
        logic [79:0] req;
        logic [31:0] crc;
        logic [31:0] got_fcs;
        if (expect_q.size() == 0) begin
            $display("reply %0d was sent with no accepted request pending", replies_seen);
            other_errors++;
        end else begin
            req = expect_q.pop_front();
            build_reply(req[79:32], req[31:0]);
            if (reply_bytes.size() != wire_len) begin
                $display("reply %0d is %0d bytes long instead of %0d",
                         replies_seen, reply_bytes.size(), wire_len);
                other_errors++;
            end else begin
                for (int i = 0; i < wire_len; i++) begin
                    if (reply_bytes[i] !== exp_reply[i]) begin
                        $display("mismatch gmii_txd reply %0d byte %0d: got %h, expected %h",
                                 replies_seen, i, reply_bytes[i], exp_reply[i]);
                        mismatches++;
                    end
                end
                // fcs against the bytes actually sent
                crc = 32'hffff_ffff;
                for (int i = 8; i < 68; i++)
                    crc = crc32_update(crc, reply_bytes[i]);
                got_fcs = {reply_bytes[71], reply_bytes[70], reply_bytes[69], reply_bytes[68]};
                if (got_fcs !== ~crc) begin
                    $display("mismatch gmii_txd fcs of reply %0d: got %h, expected %h",
                             replies_seen, got_fcs, ~crc);
                    mismatches++;
                end
            end
        end
    endtask

    // reply collector
    always @(negedge gmii_rx_clk) begin
        if (gmii_tx_en) begin
            if (!in_reply) begin
                if (replies_seen >= requests_done) begin
                    $display("gmii_tx_en rose for reply %0d before its request was received",
                             replies_seen);
                    other_errors++;
                end
                if ((replies_seen > 0) && (idle_run < 12)) begin
                    $display("only %0d idle cycles before reply %0d", idle_run, replies_seen);
                    other_errors++;
                end
                reply_bytes.delete();
                in_reply = 1'b1;
            end
            reply_bytes.push_back(gmii_txd);
        end else begin
            if (in_reply) begin
                in_reply = 1'b0;
                check_reply();
                replies_seen++;
                idle_run = 0;
            end
            idle_run++;
        end
    end

    always @(posedge gmii_rx_clk) begin
        cycles++;
        if (cycles >= timeout_cyc) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d replies still missing",
                     cycles, expect_q.size());
            $display("%0d mismatches, %0d other errors", mismatches, other_errors);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        board_ip   = 32'hc0a8_010a;
        board_mac  = 48'h0a1b_2c3d_4e5f;
        seed       = 32'h95a;
        cases[0]  = '{kind: k_none,     mac: '0, ip: '0, reply: 1'b1};
        cases[1]  = '{kind: k_bad_ip,   mac: '0, ip: '0, reply: 1'b0};
        cases[2]  = '{kind: k_unicast,  mac: '0, ip: '0, reply: 1'b0};
        cases[3]  = '{kind: k_bad_type, mac: '0, ip: '0, reply: 1'b0};
        cases[4]  = '{kind: k_bad_op,   mac: '0, ip: '0, reply: 1'b0};
        cases[5]  = '{kind: k_bad_pre,  mac: '0, ip: '0, reply: 1'b0};
        cases[6]  = '{kind: k_none,     mac: '0, ip: '0, reply: 1'b1};  // right after bad preamble
        cases[7]  = '{kind: k_bad_sfd,  mac: '0, ip: '0, reply: 1'b0};
        cases[8]  = '{kind: k_none,     mac: '0, ip: '0, reply: 1'b1};
        cases[9]  = '{kind: k_none,     mac: '0, ip: '0, reply: 1'b1};
        cases[10] = '{kind: k_none,     mac: '0, ip: '0, reply: 1'b1};
        for (int i = 0; i < num_cases; i++) begin
            r_hi = $random(seed);
            r_lo = $random(seed);
            cases[i].mac = {r_hi[15:0], r_lo};
            cases[i].ip  = $random(seed);
        end
        wait (rstn === 1'b1);
        repeat (5) begin
            @(negedge gmii_rx_clk);
            if (gmii_tx_en !== 1'b0) begin
                $display("gmii_tx_en went high before any request was sent");
                other_errors++;
            end
        end
        for (int i = 0; i < num_cases; i++)
            send_frame(cases[i]);
        while ((expect_q.size() != 0) || in_reply)
            @(negedge gmii_rx_clk);
        repeat (100) @(negedge gmii_rx_clk);          // room for a stray reply
        $display("%0d mismatches, %0d other errors", mismatches, other_errors);
        if ((mismatches == 0) && (other_errors == 0))
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- flist.f
common/arp_pkg.sv
arp_rx/arp_rx.sv
verilog/arp_req_fifo.sv
arp_tx/arp_tx.sv
verilog/arp_top.sv
test/tb_clk_gen.sv
test/arp_tb.sv

//--- Makefile
TOP = arp_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module $(TOP) \
		-f flist.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf obj_dir
